// File: src/accel_pkg.sv
package accel_pkg;

    // -------------------------------------------------------------------------
    // datapath widths
    // -------------------------------------------------------------------------

    // stream side, input and output FIFOs
    parameter int STREAM_WIDTH   = 16;
    // one data memory line
    parameter int LINE_WIDTH     = 64;
    // stream words packed per line
    parameter int WORDS_PER_LINE = LINE_WIDTH / STREAM_WIDTH;
    // lines in the data memory
    parameter int MEM_DEPTH      = 16;

    typedef logic [STREAM_WIDTH-1:0]       stream_word_t;
    typedef logic [LINE_WIDTH-1:0]         mem_line_t;
    typedef logic [$clog2(MEM_DEPTH)-1:0]  mem_addr_t;
    // counts 0..MEM_DEPTH, one bit over the address
    typedef logic [$clog2(MEM_DEPTH):0]    line_count_t;

    // controller sequence
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONFIG,
        ST_LOAD,
        ST_READ,
        ST_DONE
    } ctrl_state_t;

endpackage

// File: src/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo import accel_pkg::*; #(
    parameter int FIFO_DEPTH = 3
) (
    input  logic         clk,
    input  logic         arst_n,
    input  stream_word_t din,
    input  logic         push,
    output logic         full_n,
    output stream_word_t dout,
    input  logic         pop,
    output logic         empty_n
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

    stream_word_t     mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full_n  = (count != FULL_CNT);
    assign empty_n = (count != '0);
    // head word straight from the array
    assign dout    = mem_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr] <= din;
        end
    end

    // pointers wrap at depth, count tracks occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // callers must honour the handshake flags
    no_overflow_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && !full_n) && !(pop && !empty_n))
        else $error("stream_fifo push while full or pop while empty");

endmodule

// File: src/word_aggregator.sv
`timescale 1ns/1ps

module word_aggregator import accel_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         load_en,
    input  stream_word_t src_word,
    input  logic         src_empty_n,
    output logic         src_pop,
    input  logic         lines_to_write,
    output logic         line_wen,
    output mem_line_t    line_data
);

    localparam int IDX_W = (WORDS_PER_LINE > 1) ? $clog2(WORDS_PER_LINE) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORDS_PER_LINE - 1);

    logic [IDX_W-1:0] word_idx;
    mem_line_t        line_q;

    // no pop in the write cycle, the counter has not advanced yet
    assign src_pop   = load_en && src_empty_n && lines_to_write && !line_wen;
    assign line_data = line_q;

    // new words enter at the top, first word lands in the low bits
    always_ff @(posedge clk) begin
        if (src_pop) begin
            line_q <= {src_word, line_q[LINE_WIDTH-1:STREAM_WIDTH]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_idx <= '0;
            line_wen <= 1'b0;
        end else begin
            // write strobe one cycle after the last pop
            line_wen <= src_pop && (word_idx == LAST_IDX);
            if (src_pop) begin
                word_idx <= (word_idx == LAST_IDX) ? '0 : word_idx + 1'b1;
            end
        end
    end

endmodule

// File: src/word_deaggregator.sv
`timescale 1ns/1ps

module word_deaggregator import accel_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         lines_to_read,
    output logic         line_ren,
    input  mem_line_t    line_rdata,
    output stream_word_t dst_word,
    input  logic         dst_full_n,
    output logic         dst_push,
    output logic         busy
);

    localparam int IDX_W = (WORDS_PER_LINE > 1) ? $clog2(WORDS_PER_LINE) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORDS_PER_LINE - 1);

    // fetch waits out the registered memory read
    typedef enum logic [1:0] {
        DA_IDLE,
        DA_FETCH,
        DA_EMIT
    } deagg_state_t;

    deagg_state_t     state;
    logic [IDX_W-1:0] word_idx;
    mem_line_t        line_q;

    assign line_ren = (state == DA_IDLE) && lines_to_read;
    assign busy     = line_ren || (state != DA_IDLE);
    // full output FIFO simply holds the current word
    assign dst_push = (state == DA_EMIT) && dst_full_n;
    assign dst_word = line_q[STREAM_WIDTH-1:0];

    // capture line, then shift down one word per push
    always_ff @(posedge clk) begin
        if (state == DA_FETCH) begin
            line_q <= line_rdata;
        end else if (dst_push) begin
            line_q <= line_q >> STREAM_WIDTH;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DA_IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                DA_IDLE: begin
                    if (line_ren) begin
                        state <= DA_FETCH;
                    end
                end
                DA_FETCH: begin
                    state    <= DA_EMIT;
                    word_idx <= '0;
                end
                DA_EMIT: begin
                    if (dst_push) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == LAST_IDX) begin
                            state <= DA_IDLE;
                        end
                    end
                end
                default: state <= DA_IDLE;
            endcase
        end
    end

endmodule

// File: src/line_mem.sv
`timescale 1ns/1ps

module line_mem import accel_pkg::*; #(
    parameter int MEM_DEPTH = accel_pkg::MEM_DEPTH
) (
    input  logic      clk,
    input  logic      wen,
    input  mem_addr_t waddr,
    input  mem_line_t wdata,
    input  logic      ren,
    input  mem_addr_t raddr,
    output mem_line_t rdata
);

    mem_line_t mem [MEM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // read data one cycle after ren, held otherwise
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: src/line_counter.sv
`timescale 1ns/1ps

module line_counter import accel_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        count_load,
    input  line_count_t count_value,
    input  logic        line_wen,
    input  logic        line_ren,
    output mem_addr_t   waddr,
    output mem_addr_t   raddr,
    output logic        lines_to_write,
    output logic        lines_to_read
);

    line_count_t line_count;
    line_count_t wr_cnt;
    line_count_t rd_cnt;

    // counters never pass line_count, so the low bits are the address
    assign waddr = mem_addr_t'(wr_cnt);
    assign raddr = mem_addr_t'(rd_cnt);

    assign lines_to_write = (wr_cnt < line_count);
    // readback only starts once the whole run is in memory
    assign lines_to_read  = (rd_cnt < line_count) && (wr_cnt == line_count);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_count <= '0;
            wr_cnt     <= '0;
            rd_cnt     <= '0;
        end else if (count_load) begin
            line_count <= count_value;
            wr_cnt     <= '0;
            rd_cnt     <= '0;
        end else begin
            if (line_wen) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (line_ren) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // aggregator must stop at the configured line count
    wen_within_count: assert property (@(posedge clk) disable iff (!arst_n)
        line_wen |-> lines_to_write)
        else $error("line write past the configured line count");

endmodule

// File: src/load_controller.sv
`timescale 1ns/1ps

module load_controller import accel_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         fsm_start,
    input  stream_word_t cfg_word,
    input  logic         cfg_empty_n,
    output logic         cfg_pop,
    output logic         count_load,
    output line_count_t  count_value,
    output logic         load_en,
    input  logic         lines_to_write,
    input  logic         lines_to_read,
    input  logic         deagg_busy,
    output logic         fsm_done
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    line_count_t cfg_count;

    // oversized config clamps to a full memory
    assign cfg_count = (cfg_word > stream_word_t'(MEM_DEPTH)) ?
                       line_count_t'(MEM_DEPTH) : line_count_t'(cfg_word);

    // config word popped and loaded in the same cycle
    assign cfg_pop     = (state == ST_CONFIG) && cfg_empty_n;
    assign count_load  = cfg_pop;
    assign count_value = cfg_count;
    assign load_en     = (state == ST_LOAD);
    assign fsm_done    = (state == ST_DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (fsm_start) begin
                    state_nxt = ST_CONFIG;
                end
            end
            ST_CONFIG: begin
                // zero lines skips load and readback
                if (cfg_pop) begin
                    state_nxt = (cfg_count == '0) ? ST_DONE : ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (!lines_to_write) begin
                    state_nxt = ST_READ;
                end
            end
            ST_READ: begin
                // last word pushed and nothing left to fetch
                if (!lines_to_read && !deagg_busy) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // readback never overlaps the payload load
    load_before_read: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_READ) |-> !lines_to_write)
        else $error("readback started with lines still to write");

endmodule

// File: src/accelerator_top.sv
`timescale 1ns/1ps

module accelerator_top import accel_pkg::*; #(
    parameter int FIFO_DEPTH = 3,
    parameter int MEM_DEPTH  = accel_pkg::MEM_DEPTH
) (
    input  logic         clk,
    input  logic         arst_n,
    input  stream_word_t input_data,
    input  logic         input_vld,
    output logic         input_rdy,
    output stream_word_t output_data,
    output logic         output_vld,
    input  logic         output_rdy,
    input  logic         fsm_start,
    output logic         fsm_done
);

    // ------------------------------------------------------------------------
    // interconnect
    // ------------------------------------------------------------------------

    // input FIFO read side
    stream_word_t in_dout;
    logic         in_empty_n;
    logic         in_pop;
    logic         cfg_pop;
    logic         agg_pop;

    // output FIFO write side
    stream_word_t out_din;
    logic         out_push;
    logic         out_full_n;

    // line memory and counters
    logic         line_wen;
    mem_line_t    line_data;
    mem_addr_t    waddr;
    logic         line_ren;
    mem_line_t    line_rdata;
    mem_addr_t    raddr;
    logic         lines_to_write;
    logic         lines_to_read;

    // controller
    logic         count_load;
    line_count_t  count_value;
    logic         load_en;
    logic         deagg_busy;

    // controller and aggregator never pop together
    assign in_pop = cfg_pop | agg_pop;

    // ------------------------------------------------------------------------
    // stream FIFOs
    // ------------------------------------------------------------------------

    stream_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH              )
    ) input_fifo_inst (
        .clk        ( clk                     ),
        .arst_n     ( arst_n                  ),
        .din        ( input_data              ),
        .push       ( input_vld && input_rdy  ),
        .full_n     ( input_rdy               ),
        .dout       ( in_dout                 ),
        .pop        ( in_pop                  ),
        .empty_n    ( in_empty_n              )
    );

    stream_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH              )
    ) output_fifo_inst (
        .clk        ( clk                     ),
        .arst_n     ( arst_n                  ),
        .din        ( out_din                 ),
        .push       ( out_push                ),
        .full_n     ( out_full_n              ),
        .dout       ( output_data             ),
        .pop        ( output_rdy && output_vld ),
        .empty_n    ( output_vld              )
    );

    // ------------------------------------------------------------------------
    // load and readback path
    // ------------------------------------------------------------------------

    load_controller load_controller_inst (
        .*,
        .cfg_word    ( in_dout    ),
        .cfg_empty_n ( in_empty_n )
    );

    word_aggregator word_aggregator_inst (
        .*,
        .src_word    ( in_dout    ),
        .src_empty_n ( in_empty_n ),
        .src_pop     ( agg_pop    )
    );

    line_counter line_counter_inst (
        .*
    );

    line_mem #(
        .MEM_DEPTH   ( MEM_DEPTH  )
    ) line_mem_inst (
        .clk         ( clk        ),
        .wen         ( line_wen   ),
        .waddr       ( waddr      ),
        .wdata       ( line_data  ),
        .ren         ( line_ren   ),
        .raddr       ( raddr      ),
        .rdata       ( line_rdata )
    );

    word_deaggregator word_deaggregator_inst (
        .*,
        .dst_word    ( out_din    ),
        .dst_full_n  ( out_full_n ),
        .dst_push    ( out_push   ),
        .busy        ( deagg_busy )
    );

endmodule

// File: verification/accelerator_tb.sv
`timescale 1ns/1ps

module accelerator_tb import accel_pkg::*; ();

    // lines moved by all runs together, sizes the watchdog
    localparam int TOTAL_LINES = 1 + MEM_DEPTH + 0 + MEM_DEPTH + 3 + 5;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_LINES + 2000;

    logic         clk;
    logic         arst_n;
    stream_word_t input_data;
    logic         input_vld;
    logic         input_rdy;
    stream_word_t output_data;
    logic         output_vld;
    logic         output_rdy;
    logic         fsm_start;
    logic         fsm_done;

    int seed = 32;
    int r_gap;
    int r_rdy;
    bit random_flow;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int done_cnt;
    int out_cnt;

    // words still to offer on the input, words the output should carry
    stream_word_t send_q[$];
    stream_word_t exp_q[$];

    accelerator_top #(
        .FIFO_DEPTH  ( 3           ),
        .MEM_DEPTH   ( MEM_DEPTH   )
    ) accelerator_top_inst (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .input_data  ( input_data  ),
        .input_vld   ( input_vld   ),
        .input_rdy   ( input_rdy   ),
        .output_data ( output_data ),
        .output_vld  ( output_vld  ),
        .output_rdy  ( output_rdy  ),
        .fsm_start   ( fsm_start   ),
        .fsm_done    ( fsm_done    )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // compare tasks and reference model
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input stream_word_t act,
                              input stream_word_t exp);
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    // counts above the memory size clamp to a full memory
    function automatic int expected_lines(input stream_word_t cfg);
        return (cfg > MEM_DEPTH) ? MEM_DEPTH : int'(cfg);
    endfunction

    // config word first, then whole lines of random payload
    task automatic queue_run(input stream_word_t cfg, inout int words);
        stream_word_t w;
        send_q.push_back(cfg);
        repeat (expected_lines(cfg) * WORDS_PER_LINE) begin
            w = $random(seed);
            send_q.push_back(w);
            exp_q.push_back(w);
            words++;
        end
    endtask

    // ------------------------------------------------------------------------
    // stream source and sink
    // ------------------------------------------------------------------------

    initial begin
        forever begin
            @(posedge clk);
            if (input_vld && input_rdy) begin
                void'(send_q.pop_front());
            end
            if (fsm_done) begin
                done_cnt++;
            end
            if (output_vld && output_rdy) begin
                out_cnt++;
                if (exp_q.size() == 0) begin
                    $display("unexpected output word %h at %0t ns", output_data, $time);
                    err_cnt++;
                end else begin
                    check_word("output_data", output_data, exp_q.pop_front());
                end
            end
            // two draws every cycle keep the random sequence fixed
            @(negedge clk);
            r_gap = $random(seed);
            r_rdy = $random(seed);
            if (send_q.size() > 0 && (!random_flow || r_gap[1:0] != 2'b00)) begin
                input_vld  = 1'b1;
                input_data = send_q[0];
            end else begin
                input_vld  = 1'b0;
            end
            output_rdy = !random_flow || r_rdy[0];
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    task automatic pulse_start();
        @(negedge clk);
        fsm_start = 1'b1;
        @(negedge clk);
        fsm_start = 1'b0;
    endtask

    // done must be a single cycle wide
    task automatic wait_done();
        do @(posedge clk); while (fsm_done !== 1'b1);
        @(posedge clk);
        check_flag("fsm_done", fsm_done, 1'b0);
    endtask

    task automatic report_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            pass_cnt++;
            $display("%-16s pass", name);
        end else begin
            fail_cnt++;
            $display("%-16s fail, %0d errors", name, err_cnt - err_start);
        end
    endtask

    task automatic run_test(input string name, input bit flow, input int runs,
                            input stream_word_t cfg_a, input stream_word_t cfg_b);
        int err_start;
        int words;
        err_start = err_cnt;
        words     = 0;
        @(posedge clk);
        random_flow = flow;
        done_cnt    = 0;
        out_cnt     = 0;
        // second run is queued up front, so its words wait in the input FIFO
        queue_run(cfg_a, words);
        if (runs > 1) begin
            queue_run(cfg_b, words);
        end
        repeat (runs) begin
            pulse_start();
            wait_done();
        end
        while (exp_q.size() != 0 || send_q.size() != 0) @(negedge clk);
        if (done_cnt != runs) begin
            $display("fsm_done pulsed %0d times instead of %0d", done_cnt, runs);
            err_cnt++;
        end
        if (out_cnt != words) begin
            $display("%0d output words seen instead of %0d", out_cnt, words);
            err_cnt++;
        end
        report_test(name, err_start);
    endtask

    initial begin
        int err_start;
        arst_n     = 1'b0;
        input_data = '0;
        input_vld  = 1'b0;
        output_rdy = 1'b0;
        fsm_start  = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        err_start = err_cnt;
        @(negedge clk);
        check_flag("output_vld", output_vld, 1'b0);
        check_flag("fsm_done", fsm_done, 1'b0);
        check_flag("input_rdy", input_rdy, 1'b1);
        report_test("reset levels", err_start);

        run_test("single line", 1'b0, 1, 16'd1, 16'd0);
        run_test("full memory", 1'b1, 1, stream_word_t'(MEM_DEPTH), 16'd0);
        run_test("zero count", 1'b1, 1, 16'd0, 16'd0);
        run_test("saturated count", 1'b1, 1, 16'h0123, 16'd0);
        run_test("back to back", 1'b1, 2, 16'd3, 16'd5);

        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bounds the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// File: compile.f
src/accel_pkg.sv
src/stream_fifo.sv
src/word_aggregator.sv
src/word_deaggregator.sv
src/line_mem.sv
src/line_counter.sv
src/load_controller.sv
src/accelerator_top.sv
verification/accelerator_tb.sv

// File: Bender.yml
package:
  name: accelerator

sources:
  - src/accel_pkg.sv
  - src/stream_fifo.sv
  - src/word_aggregator.sv
  - src/word_deaggregator.sv
  - src/line_mem.sv
  - src/line_counter.sv
  - src/load_controller.sv
  - src/accelerator_top.sv
  - target: test
    files:
      - verification/accelerator_tb.sv
